// ==== alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// data word and reorder-buffer tag widths.
`define WORD_W      32
`define TAG_W       4

// reservation station depth. The index width has to cover every slot.
`define RS_ENTRIES  4
`define RS_IDX_W    2

// alu op codes. Code 15 is left unassigned.
`define OP_W        4
`define ALU_ADD     4'd0
`define ALU_ADDU    4'd1
`define ALU_SUB     4'd2
`define ALU_SUBU    4'd3
`define ALU_AND     4'd4
`define ALU_OR      4'd5
`define ALU_NOR     4'd6
`define ALU_XOR     4'd7
`define ALU_SLL     4'd8
`define ALU_SRL     4'd9
`define ALU_SRA     4'd10
`define ALU_ROR     4'd11
`define ALU_SEQ     4'd12
`define ALU_SLT     4'd13
`define ALU_SLTU    4'd14

`endif

// ==== alu_pkg.sv ====
`default_nettype none

`include "alu_cfg.svh"

package alu_pkg;

  // one data word, as carried by operands and results.
  typedef logic [`WORD_W-1:0] word_t;

  // reorder-buffer tag of an instruction that is in flight.
  // a waiting operand holds the tag of the result it needs.
  typedef logic [`TAG_W-1:0] tag_t;

  // alu operation code, see the ALU_* codes in the cfg header.
  typedef logic [`OP_W-1:0] alu_op_t;

endpackage

`default_nettype wire

// ==== alu_ifs.sv ====
`default_nettype none

// one instruction handed from dispatch to the reservation station.
interface dispatch_if;
  import alu_pkg::*;

  logic    valid;
  tag_t    tag;
  alu_op_t op;
  word_t   src1;
  logic    src1_rdy;
  tag_t    src1_tag;
  word_t   src2;
  logic    src2_rdy;
  tag_t    src2_tag;

  modport source (
    output valid, tag, op,
    output src1, src1_rdy, src1_tag,
    output src2, src2_rdy, src2_tag
  );

  modport sink (
    input valid, tag, op,
    input src1, src1_rdy, src1_tag,
    input src2, src2_rdy, src2_tag
  );
endinterface

// a result broadcast. valid is a single-cycle strobe with no back-pressure.
interface result_bus_if;
  import alu_pkg::*;

  logic  valid;
  tag_t  tag;
  word_t value;

  modport producer (output valid, tag, value);
  modport snoop (input valid, tag, value);
endinterface

`default_nettype wire

// ==== alu_rs.sv ====
`default_nettype none

`include "alu_cfg.svh"

module alu_rs (
  input  logic             clk,
  input  logic             rst,
  dispatch_if.sink         disp,
  result_bus_if.snoop      cdb,
  result_bus_if.snoop      alu_res,
  output logic             full,
  output logic             issue,
  output alu_pkg::tag_t    issue_tag,
  output alu_pkg::alu_op_t issue_op,
  output alu_pkg::word_t   issue_src1,
  output alu_pkg::word_t   issue_src2
);

  import alu_pkg::*;

  typedef logic [`RS_IDX_W-1:0] rs_idx_t;

  logic [`RS_ENTRIES-1:0] ent_valid;
  logic [`RS_ENTRIES-1:0] valid_nxt;
  logic [`RS_ENTRIES-1:0] ent_ready;
  tag_t                   ent_tag [`RS_ENTRIES];
  alu_op_t                ent_op [`RS_ENTRIES];

  logic [`RS_ENTRIES-1:0] s1_rdy;
  tag_t                   s1_tag [`RS_ENTRIES];
  word_t                  s1_val [`RS_ENTRIES];
  logic [`RS_ENTRIES-1:0] s2_rdy;
  tag_t                   s2_tag [`RS_ENTRIES];
  word_t                  s2_val [`RS_ENTRIES];

  logic    alloc_ok;
  rs_idx_t alloc_idx;
  rs_idx_t issue_idx;

  logic    new_s1_rdy;
  word_t   new_s1_val;
  logic    new_s2_rdy;
  word_t   new_s2_val;

  // true when a bus broadcast supplies an operand that is still waiting.
  function automatic logic snoop_hit(input logic bus_valid, input tag_t bus_tag,
                                     input logic rdy, input tag_t want);
    return !rdy && bus_valid && (bus_tag == want);
  endfunction

  // lowest free slot takes the next dispatch.
  always_comb begin
    alloc_ok  = 1'b0;
    alloc_idx = '0;
    for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        alloc_ok  = 1'b1;
        alloc_idx = rs_idx_t'(i);
      end
    end
  end

  // the lowest ready slot wins the issue port.
  assign ent_ready = ent_valid & s1_rdy & s2_rdy;

  always_comb begin
    issue_idx = '0;
    for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
      if (ent_ready[i]) begin
        issue_idx = rs_idx_t'(i);
      end
    end
  end

  assign issue      = |ent_ready;
  assign issue_tag  = ent_tag[issue_idx];
  assign issue_op   = ent_op[issue_idx];
  assign issue_src1 = s1_val[issue_idx];
  assign issue_src2 = s2_val[issue_idx];

  // a broadcast in the dispatch cycle is captured straight into the new entry.
  always_comb begin
    new_s1_rdy = disp.src1_rdy;
    new_s1_val = disp.src1;
    if (snoop_hit(cdb.valid, cdb.tag, disp.src1_rdy, disp.src1_tag)) begin
      new_s1_rdy = 1'b1;
      new_s1_val = cdb.value;
    end else if (snoop_hit(alu_res.valid, alu_res.tag, disp.src1_rdy, disp.src1_tag)) begin
      new_s1_rdy = 1'b1;
      new_s1_val = alu_res.value;
    end

    new_s2_rdy = disp.src2_rdy;
    new_s2_val = disp.src2;
    if (snoop_hit(cdb.valid, cdb.tag, disp.src2_rdy, disp.src2_tag)) begin
      new_s2_rdy = 1'b1;
      new_s2_val = cdb.value;
    end else if (snoop_hit(alu_res.valid, alu_res.tag, disp.src2_rdy, disp.src2_tag)) begin
      new_s2_rdy = 1'b1;
      new_s2_val = alu_res.value;
    end
  end

  // a slot freed by issue is not reused until the following cycle.
  always_comb begin
    valid_nxt = ent_valid;
    if (issue) begin
      valid_nxt[issue_idx] = 1'b0;
    end
    if (disp.valid && alloc_ok) begin
      valid_nxt[alloc_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid <= '0;
      full      <= 1'b0;
    end else begin
      ent_valid <= valid_nxt;
      full      <= &valid_nxt;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `RS_ENTRIES; i++) begin
      if (snoop_hit(cdb.valid, cdb.tag, s1_rdy[i], s1_tag[i])) begin
        s1_rdy[i] <= 1'b1;
        s1_val[i] <= cdb.value;
      end else if (snoop_hit(alu_res.valid, alu_res.tag, s1_rdy[i], s1_tag[i])) begin
        s1_rdy[i] <= 1'b1;
        s1_val[i] <= alu_res.value;
      end
      if (snoop_hit(cdb.valid, cdb.tag, s2_rdy[i], s2_tag[i])) begin
        s2_rdy[i] <= 1'b1;
        s2_val[i] <= cdb.value;
      end else if (snoop_hit(alu_res.valid, alu_res.tag, s2_rdy[i], s2_tag[i])) begin
        s2_rdy[i] <= 1'b1;
        s2_val[i] <= alu_res.value;
      end
    end
    // the allocated slot is empty, so this write never races a wakeup.
    if (disp.valid && alloc_ok) begin
      ent_tag[alloc_idx] <= disp.tag;
      ent_op[alloc_idx]  <= disp.op;
      s1_rdy[alloc_idx]  <= new_s1_rdy;
      s1_tag[alloc_idx]  <= disp.src1_tag;
      s1_val[alloc_idx]  <= new_s1_val;
      s2_rdy[alloc_idx]  <= new_s2_rdy;
      s2_tag[alloc_idx]  <= disp.src2_tag;
      s2_val[alloc_idx]  <= new_s2_val;
    end
  end

  no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
    disp.valid |-> !full)
    else $error("alu_rs: dispatch while the station is full.");

  // an issued slot had both operands in hand and is empty one cycle later.
  issue_ready_then_freed: assert property (@(posedge clk) disable iff (rst)
    issue |-> (s1_rdy[issue_idx] && s2_rdy[issue_idx]) ##1 !ent_valid[$past(issue_idx)])
    else $error("alu_rs: issued slot was not ready or was not freed.");

  no_shared_tag_on_buses: assert property (@(posedge clk) disable iff (rst)
    (cdb.valid && alu_res.valid) |-> (cdb.tag != alu_res.tag))
    else $error("alu_rs: cdb and alu result carry the same tag.");

endmodule

`default_nettype wire

// ==== alu_exec.sv ====
`default_nettype none

`include "alu_cfg.svh"

module alu_exec (
  input  logic             clk,
  input  logic             rst,
  input  logic             issue,
  input  alu_pkg::tag_t    issue_tag,
  input  alu_pkg::alu_op_t issue_op,
  input  alu_pkg::word_t   issue_src1,
  input  alu_pkg::word_t   issue_src2,
  result_bus_if.producer   res
);

  import alu_pkg::*;

  localparam int SHAMT_W = $clog2(`WORD_W);

  logic [SHAMT_W-1:0]    shamt;
  logic [2*`WORD_W-1:0]  rot;
  word_t                 result;

  // shifts and rotates move src1 by the low bits of src2.
  assign shamt = issue_src2[SHAMT_W-1:0];

  // rotate right by shifting a doubled copy of the word.
  assign rot = {issue_src1, issue_src1} >> shamt;

  always_comb begin
    case (issue_op)
      `ALU_ADD,
      `ALU_ADDU: result = issue_src1 + issue_src2;
      `ALU_SUB,
      `ALU_SUBU: result = issue_src1 - issue_src2;
      `ALU_AND:  result = issue_src1 & issue_src2;
      `ALU_OR:   result = issue_src1 | issue_src2;
      `ALU_NOR:  result = ~(issue_src1 | issue_src2);
      `ALU_XOR:  result = issue_src1 ^ issue_src2;
      `ALU_SLL:  result = issue_src1 << shamt;
      `ALU_SRL:  result = issue_src1 >> shamt;
      `ALU_SRA:  result = $signed(issue_src1) >>> shamt;
      `ALU_ROR:  result = rot[`WORD_W-1:0];
      `ALU_SEQ:  result = word_t'(issue_src1 == issue_src2);
      `ALU_SLT:  result = word_t'($signed(issue_src1) < $signed(issue_src2));
      `ALU_SLTU: result = word_t'(issue_src1 < issue_src2);
      default:   result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res.valid <= 1'b0;
    end else begin
      res.valid <= issue;
    end
  end

  // tag and value only move when an instruction issues.
  always_ff @(posedge clk) begin
    if (issue) begin
      res.tag   <= issue_tag;
      res.value <= result;
    end
  end

  // the station only holds ops that dispatch handed it, never the spare code.
  no_unused_op: assert property (@(posedge clk) disable iff (rst)
    issue |-> (issue_op != {`OP_W{1'b1}}))
    else $error("alu_exec: issued the unassigned op code.");

endmodule

`default_nettype wire

// ==== alu_cluster.sv ====
`default_nettype none

module alu_cluster (
  input  logic             clk,
  input  logic             rst,

  input  logic             disp_valid,
  input  alu_pkg::tag_t    disp_tag,
  input  alu_pkg::alu_op_t disp_op,
  input  alu_pkg::word_t   disp_src1,
  input  alu_pkg::word_t   disp_src2,
  input  logic             disp_src1_rdy,
  input  logic             disp_src2_rdy,
  input  alu_pkg::tag_t    disp_src1_tag,
  input  alu_pkg::tag_t    disp_src2_tag,

  input  logic             cdb_valid,
  input  alu_pkg::tag_t    cdb_tag,
  input  alu_pkg::word_t   cdb_value,

  output logic             full,
  output logic             res_valid,
  output alu_pkg::tag_t    res_tag,
  output alu_pkg::word_t   res_value
);

  import alu_pkg::*;

  logic    issue;
  tag_t    issue_tag;
  alu_op_t issue_op;
  word_t   issue_src1;
  word_t   issue_src2;

  dispatch_if   disp ();
  result_bus_if cdb ();
  result_bus_if alu_res ();

  assign disp.valid    = disp_valid;
  assign disp.tag      = disp_tag;
  assign disp.op       = disp_op;
  assign disp.src1     = disp_src1;
  assign disp.src1_rdy = disp_src1_rdy;
  assign disp.src1_tag = disp_src1_tag;
  assign disp.src2     = disp_src2;
  assign disp.src2_rdy = disp_src2_rdy;
  assign disp.src2_tag = disp_src2_tag;

  // results from units outside the cluster.
  assign cdb.valid = cdb_valid;
  assign cdb.tag   = cdb_tag;
  assign cdb.value = cdb_value;

  // the cluster's own result leaves on the res ports.
  assign res_valid = alu_res.valid;
  assign res_tag   = alu_res.tag;
  assign res_value = alu_res.value;

  alu_rs i_alu_rs (
    .clk        (clk),
    .rst        (rst),
    .disp       (disp),
    .cdb        (cdb),
    .alu_res    (alu_res),
    .full       (full),
    .issue      (issue),
    .issue_tag  (issue_tag),
    .issue_op   (issue_op),
    .issue_src1 (issue_src1),
    .issue_src2 (issue_src2)
  );

  alu_exec i_alu_exec (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .issue_tag  (issue_tag),
    .issue_op   (issue_op),
    .issue_src1 (issue_src1),
    .issue_src2 (issue_src2),
    .res        (alu_res)
  );

endmodule

`default_nettype wire

// ==== tb_alu_cluster.sv ====
`default_nettype none

`include "alu_cfg.svh"

module tb_alu_cluster;

  import alu_pkg::*;

  localparam int N_TAGS   = 1 << `TAG_W;
  localparam int N_IDLE   = 30;
  localparam int N_CHAIN  = 8;
  localparam int N_RANDOM = 200;
  localparam int N_INSTR  = N_IDLE + 3 + N_CHAIN + 5 + N_RANDOM;

  logic    clk;
  logic    rst;
  logic    disp_valid;
  tag_t    disp_tag;
  alu_op_t disp_op;
  word_t   disp_src1;
  word_t   disp_src2;
  logic    disp_src1_rdy;
  logic    disp_src2_rdy;
  tag_t    disp_src1_tag;
  tag_t    disp_src2_tag;
  logic    cdb_valid;
  tag_t    cdb_tag;
  word_t   cdb_value;
  logic    full;
  logic    res_valid;
  tag_t    res_tag;
  word_t   res_value;

  integer  seed;
  string   test_name;
  logic    idle_mode;
  logic    auto_cdb;
  logic    ext_alloc;
  tag_t    ext_alloc_tag;
  tag_t    next_tag;
  int      last_alu;
  int      prev_alu;
  tag_t    pend_ext [$];

  // reference model, one record per tag.
  logic    busy [N_TAGS];
  logic    ext [N_TAGS];
  alu_op_t m_op [N_TAGS];
  logic    a_rdy [N_TAGS];
  tag_t    a_tag [N_TAGS];
  word_t   a_val [N_TAGS];
  logic    b_rdy [N_TAGS];
  tag_t    b_tag [N_TAGS];
  word_t   b_val [N_TAGS];
  int      disp_cnt;
  int      res_cnt;
  word_t   exp_res;
  logic    exp_full;
  logic    res_tag_ok;
  logic    res_srcs_ok;

  alu_cluster i_alu_cluster (
    .clk           (clk),
    .rst           (rst),
    .disp_valid    (disp_valid),
    .disp_tag      (disp_tag),
    .disp_op       (disp_op),
    .disp_src1     (disp_src1),
    .disp_src2     (disp_src2),
    .disp_src1_rdy (disp_src1_rdy),
    .disp_src2_rdy (disp_src2_rdy),
    .disp_src1_tag (disp_src1_tag),
    .disp_src2_tag (disp_src2_tag),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .cdb_value     (cdb_value),
    .full          (full),
    .res_valid     (res_valid),
    .res_tag       (res_tag),
    .res_value     (res_value)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    stop_on_error($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
  endtask

  function automatic word_t expected_result(input alu_op_t op, input word_t a, input word_t b);
    logic [4:0] s;
    s = b[4:0];
    case (op)
      `ALU_ADD, `ALU_ADDU: return a + b;
      `ALU_SUB, `ALU_SUBU: return a - b;
      `ALU_AND:  return a & b;
      `ALU_OR:   return a | b;
      `ALU_NOR:  return ~(a | b);
      `ALU_XOR:  return a ^ b;
      `ALU_SLL:  return a << s;
      `ALU_SRL:  return a >> s;
      `ALU_SRA:  return word_t'($signed(a) >>> s);
      // a rotate by zero leaves the word as it is, the left part shifts out.
      `ALU_ROR:  return (a >> s) | (a << (6'd32 - {1'b0, s}));
      `ALU_SEQ:  return (a == b) ? 32'd1 : 32'd0;
      `ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:   return '0;
    endcase
  endfunction

  // the model follows each cycle at the falling edge, when all inputs are stable.
  always @(negedge clk) begin
    if (rst) begin
      for (int t = 0; t < N_TAGS; t++) begin
        busy[t] = 1'b0;
        ext[t]  = 1'b0;
      end
      disp_cnt    = 0;
      res_cnt     = 0;
      exp_res     = '0;
      exp_full    = 1'b0;
      res_tag_ok  = 1'b1;
      res_srcs_ok = 1'b1;
    end else begin
      if (res_valid) begin
        res_tag_ok  = busy[res_tag] && !ext[res_tag];
        res_srcs_ok = a_rdy[res_tag] && b_rdy[res_tag];
        exp_res     = expected_result(m_op[res_tag], a_val[res_tag], b_val[res_tag]);
        res_cnt     = res_cnt + 1;
      end
      // a result this cycle means its slot was freed on the edge that opened the cycle.
      exp_full = (disp_cnt - res_cnt) == `RS_ENTRIES;
      if (disp_valid) begin
        busy[disp_tag]  = 1'b1;
        ext[disp_tag]   = 1'b0;
        m_op[disp_tag]  = disp_op;
        a_rdy[disp_tag] = disp_src1_rdy;
        a_tag[disp_tag] = disp_src1_tag;
        a_val[disp_tag] = disp_src1;
        b_rdy[disp_tag] = disp_src2_rdy;
        b_tag[disp_tag] = disp_src2_tag;
        b_val[disp_tag] = disp_src2;
        disp_cnt        = disp_cnt + 1;
      end
      if (ext_alloc) begin
        busy[ext_alloc_tag] = 1'b1;
        ext[ext_alloc_tag]  = 1'b1;
      end
      for (int t = 0; t < N_TAGS; t++) begin
        if (busy[t] && !ext[t]) begin
          if (!a_rdy[t] && cdb_valid && a_tag[t] == cdb_tag) begin
            a_rdy[t] = 1'b1;
            a_val[t] = cdb_value;
          end else if (!a_rdy[t] && res_valid && a_tag[t] == res_tag) begin
            a_rdy[t] = 1'b1;
            a_val[t] = exp_res;
          end
          if (!b_rdy[t] && cdb_valid && b_tag[t] == cdb_tag) begin
            b_rdy[t] = 1'b1;
            b_val[t] = cdb_value;
          end else if (!b_rdy[t] && res_valid && b_tag[t] == res_tag) begin
            b_rdy[t] = 1'b1;
            b_val[t] = exp_res;
          end
        end
      end
      if (cdb_valid) begin
        busy[cdb_tag] = 1'b0;
      end
      if (res_valid) begin
        busy[res_tag] = 1'b0;
      end
    end
  end

  reset_clears: assert property (@(posedge clk) rst |=> (!full && !res_valid))
    else stop_on_error("full or res_valid is high right after reset");

  res_in_flight: assert property (@(posedge clk) disable iff (rst) res_valid |-> res_tag_ok)
    else stop_on_error($sformatf("result tag %0d is not in flight", $sampled(res_tag)));

  res_after_operands: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> res_srcs_ok)
    else stop_on_error("a result appeared before its operands were broadcast");

  res_value_check: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> (res_value == exp_res))
    else report_mismatch(test_name, exp_res, $sampled(res_value));

  full_check: assert property (@(posedge clk) disable iff (rst) full == exp_full)
    else report_mismatch({test_name, " full"}, word_t'(exp_full), word_t'($sampled(full)));

  idle_latency: assert property (@(posedge clk) disable iff (rst)
    (disp_valid && idle_mode) |-> ##2 (res_valid && res_tag == $past(disp_tag, 2)))
    else stop_on_error("an idle instruction did not complete 2 cycles after dispatch");

  no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
    disp_valid |-> !full)
    else stop_on_error("the testbench dispatched while full was high");

  task automatic send_cdb();
    cdb_valid <= 1'b1;
    cdb_tag   <= pend_ext.pop_front();
    cdb_value <= word_t'($random(seed));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    disp_valid <= 1'b0;
    cdb_valid  <= 1'b0;
    ext_alloc  <= 1'b0;
    if (auto_cdb && pend_ext.size() > 0 && ($random(seed) & 3) == 0) begin
      send_cdb();
    end
  endtask

  // occupancy from the model is at most one cycle late, so it never overfills.
  task automatic dispatch_instr(input alu_op_t op, input int dep1, input int dep2,
                                input bit with_cdb);
    logic  wait1;
    logic  wait2;
    word_t v1;
    word_t v2;
    next_cycle();
    while (busy[next_tag] || (disp_cnt - res_cnt) >= `RS_ENTRIES) begin
      next_cycle();
    end
    wait1 = (dep1 >= 0) ? busy[tag_t'(dep1)] : 1'b0;
    wait2 = (dep2 >= 0) ? busy[tag_t'(dep2)] : 1'b0;
    v1 = word_t'($random(seed));
    v2 = word_t'($random(seed));
    // half of the SEQ instructions compare a value with itself.
    if (op == `ALU_SEQ && v2[0]) begin
      v2 = v1;
    end
    disp_valid    <= 1'b1;
    disp_tag      <= next_tag;
    disp_op       <= op;
    disp_src1     <= v1;
    disp_src1_rdy <= !wait1;
    disp_src1_tag <= tag_t'(dep1);
    disp_src2     <= v2;
    disp_src2_rdy <= !wait2;
    disp_src2_tag <= tag_t'(dep2);
    if (with_cdb) begin
      send_cdb();
    end
    prev_alu = last_alu;
    last_alu = int'(next_tag);
    next_tag = next_tag + 1'b1;
  endtask

  task automatic open_ext_tag(output tag_t t);
    next_cycle();
    while (busy[next_tag]) begin
      next_cycle();
    end
    ext_alloc     <= 1'b1;
    ext_alloc_tag <= next_tag;
    pend_ext.push_back(next_tag);
    t = next_tag;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic drain();
    next_cycle();
    while (disp_cnt != res_cnt || pend_ext.size() != 0) begin
      next_cycle();
    end
  endtask

  function automatic alu_op_t random_op();
    return alu_op_t'($unsigned($random(seed)) % 15);
  endfunction

  function automatic int choose_source();
    int pick;
    pick = int'($unsigned($random(seed)) % 3);
    if (pick == 1) begin
      return last_alu;
    end else if (pick == 2 && pend_ext.size() > 0) begin
      return int'(pend_ext[$unsigned($random(seed)) % pend_ext.size()]);
    end
    return -1;
  endfunction

  initial begin : watchdog
    repeat (N_INSTR * 40 + 200) @(posedge clk);
    stop_on_error("the run hung and did not finish in time");
  end

  initial begin : stimulus
    tag_t x [4];
    seed          = 32'h974fdc9e;
    test_name     = "reset";
    idle_mode     = 1'b0;
    auto_cdb      = 1'b0;
    next_tag      = '0;
    last_alu      = -1;
    prev_alu      = -1;
    rst           = 1'b1;
    disp_valid    = 1'b0;
    disp_tag      = '0;
    disp_op       = '0;
    disp_src1     = '0;
    disp_src2     = '0;
    disp_src1_rdy = 1'b0;
    disp_src2_rdy = 1'b0;
    disp_src1_tag = '0;
    disp_src2_tag = '0;
    cdb_valid     = 1'b0;
    cdb_tag       = '0;
    cdb_value     = '0;
    ext_alloc     = 1'b0;
    ext_alloc_tag = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    test_name = "independent";
    idle_mode = 1'b1;
    for (int i = 0; i < N_IDLE; i++) begin
      dispatch_instr(alu_op_t'(i % 15), -1, -1, 1'b0);
      drain();
    end
    idle_mode = 1'b0;

    test_name = "external";
    open_ext_tag(x[0]);
    dispatch_instr(`ALU_ADD, int'(x[0]), -1, 1'b0);
    repeat (5) next_cycle();
    next_cycle();
    send_cdb();
    drain();
    // the broadcast lands in the dispatch cycle itself.
    open_ext_tag(x[1]);
    dispatch_instr(`ALU_SUB, -1, int'(x[1]), 1'b1);
    drain();
    open_ext_tag(x[2]);
    open_ext_tag(x[3]);
    dispatch_instr(`ALU_XOR, int'(x[2]), int'(x[3]), 1'b0);
    next_cycle();
    send_cdb();
    repeat (3) next_cycle();
    send_cdb();
    drain();

    test_name = "chain";
    dispatch_instr(random_op(), -1, -1, 1'b0);
    for (int i = 1; i < N_CHAIN; i++) begin
      dispatch_instr(random_op(), last_alu, (i % 2 == 1) ? prev_alu : -1, 1'b0);
    end
    drain();

    test_name = "full";
    for (int i = 0; i < 4; i++) begin
      open_ext_tag(x[i]);
    end
    for (int i = 0; i < 4; i++) begin
      dispatch_instr(random_op(), int'(x[i]), -1, 1'b0);
    end
    repeat (6) next_cycle();
    next_cycle();
    send_cdb();
    dispatch_instr(`ALU_ADD, -1, -1, 1'b0);
    for (int i = 0; i < 3; i++) begin
      next_cycle();
      send_cdb();
    end
    drain();

    test_name = "random";
    auto_cdb = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      if (($random(seed) & 3) == 0) begin
        open_ext_tag(x[0]);
      end else begin
        dispatch_instr(random_op(), choose_source(), choose_source(), 1'b0);
      end
    end
    drain();
    repeat (4) next_cycle();

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
alu_pkg.sv
alu_ifs.sv
alu_rs.sv
alu_exec.sv
alu_cluster.sv
tb_alu_cluster.sv

// ==== Makefile ====
SIM  := obj_dir/Vtb_alu_cluster
SRCS := $(filter-out +%,$(shell cat project.f))

.PHONY: run clean

run: $(SIM)
	./$(SIM)

# rebuilt only when a source, the cfg header or the file list changes.
$(SIM): project.f $(SRCS) alu_cfg.svh
	verilator --binary --timing --assert --top-module tb_alu_cluster \
	  -f project.f -o Vtb_alu_cluster

clean:
	rm -rf obj_dir
